// File: sim.f
+incdir+verilog
+incdir+sim
verilog/keccak_pkg.sv
verilog/lane_ram.sv
verilog/lane_bus_arbiter.sv
verilog/lane_stream_port.sv
verilog/round_constant_gen.sv
verilog/round_engine.sv
verilog/keccak_perm_top.sv
sim/tb_keccak_perm.sv

// File: sim/keccak_ref_model.svh
// software Keccak-f[1600] model working on a 25-lane array
`ifndef KECCAK_REF_MODEL_SVH
`define KECCAK_REF_MODEL_SVH

`include "keccak_config.svh"

// state operated on in place, lanes ordered by x + 5*y
logic [`KECCAK_LANE_W-1:0] model_st [`KECCAK_LANES];

function automatic logic [`KECCAK_LANE_W-1:0] model_rotl(
	logic [`KECCAK_LANE_W-1:0] v, int n);
	int k;
	k = n % `KECCAK_LANE_W;
	if (k == 0) begin
		return v;
	end
	return (v << k) | (v >> (`KECCAK_LANE_W - k));
endfunction

// bit t of the degree-8 rc sequence, stepped one bit at a time
function automatic logic model_rc_bit(int t);
	logic [8:0] r;
	r = 9'h001;
	for (int i = 0; i < t % 255; i++) begin
		r = r << 1;
		r[0] = r[0] ^ r[8];
		r[4] = r[4] ^ r[8];
		r[5] = r[5] ^ r[8];
		r[6] = r[6] ^ r[8];
		r[8] = 1'b0;
	end
	return r[0];
endfunction

function automatic logic [`KECCAK_LANE_W-1:0] model_round_const(int ir);
	logic [`KECCAK_LANE_W-1:0] rc;
	rc = '0;
	for (int j = 0; j <= 6; j++) begin
		rc[(1 << j) - 1] = model_rc_bit(j + 7 * ir);
	end
	return rc;
endfunction

function automatic void model_permute();
	logic [`KECCAK_LANE_W-1:0] c [5];
	logic [`KECCAK_LANE_W-1:0] b [25];
	int rho [25];
	int x;
	int y;
	int nx;
	// offsets follow the orbit of (1,0) under (x,y) -> (y, 2x+3y)
	rho[0] = 0;
	x = 1;
	y = 0;
	for (int t = 0; t < 24; t++) begin
		rho[x + 5 * y] = ((t + 1) * (t + 2) / 2) % 64;
		nx = y;
		y = (2 * x + 3 * y) % 5;
		x = nx;
	end
	for (int ir = 0; ir < `KECCAK_ROUNDS; ir++) begin
		// theta
		for (int xi = 0; xi < 5; xi++) begin
			c[xi] = model_st[xi] ^ model_st[xi + 5] ^ model_st[xi + 10] ^
				model_st[xi + 15] ^ model_st[xi + 20];
		end
		for (int xi = 0; xi < 5; xi++) begin
			for (int yi = 0; yi < 5; yi++) begin
				model_st[xi + 5 * yi] ^= c[(xi + 4) % 5] ^ model_rotl(c[(xi + 1) % 5], 1);
			end
		end
		// rho and pi together
		for (int xi = 0; xi < 5; xi++) begin
			for (int yi = 0; yi < 5; yi++) begin
				b[yi + 5 * ((2 * xi + 3 * yi) % 5)] =
					model_rotl(model_st[xi + 5 * yi], rho[xi + 5 * yi]);
			end
		end
		// chi
		for (int xi = 0; xi < 5; xi++) begin
			for (int yi = 0; yi < 5; yi++) begin
				model_st[xi + 5 * yi] = b[xi + 5 * yi] ^
					(~b[(xi + 1) % 5 + 5 * yi] & b[(xi + 2) % 5 + 5 * yi]);
			end
		end
		// iota
		model_st[0] ^= model_round_const(ir);
	end
endfunction

`endif

// File: sim/tb_keccak_perm.sv
// testbench for keccak_perm_top with stream stimulus, watchdog and checking assertions
`timescale 1ns/1ps
`default_nettype none
`include "keccak_config.svh"

module tb_keccak_perm
	import keccak_pkg::*;
();

	`include "keccak_ref_model.svh"

	localparam int NUM_BLOCKS = 5;
	// a round is about 250 cycles of two-cycle RAM accesses
	localparam int BLOCK_CYCLES = 25 * 4 + `KECCAK_ROUNDS * 300 + 25 * 16;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * BLOCK_CYCLES + 2000;

	logic clk;
	logic rst;
	logic pushin;
	logic firstin;
	lane_t din;
	logic stopin;
	logic pushout;
	logic firstout;
	lane_t dout;
	logic stopout;

	integer seed;
	logic zero_block;
	logic held;
	logic [4:0] in_cnt;
	logic [4:0] out_cnt;
	int blocks_done;
	lane_t in_lanes [`KECCAK_LANES];
	lane_t exp_lanes [`KECCAK_LANES];
	lane_t exp_out;
	lane_t prev_dout;
	logic prev_firstout;

	keccak_perm_top i_dut (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.firstin(firstin),
		.din(din),
		.stopin(stopin),
		.pushout(pushout),
		.firstout(firstout),
		.dout(dout),
		.stopout(stopout)
	);

	always #5 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	function automatic lane_t random_lane();
		return {$random(seed), $random(seed)};
	endfunction

	// called 1 ns after an edge, returns 1 ns after the edge that took the lane
	task automatic push_lane(input lane_t d, input logic first);
		pushin = 1'b1;
		firstin = first;
		din = d;
		while (stopin) begin
			@(posedge clk);
			#1;
		end
		@(posedge clk);
		#1;
		pushin = 1'b0;
		firstin = 1'b0;
	endtask

	// idle pushes that carry no firstin
	task automatic push_without_first(input int n);
		for (int i = 0; i < n; i++) begin
			pushin = 1'b1;
			firstin = 1'b0;
			din = random_lane();
			@(posedge clk);
			#1;
		end
		pushin = 1'b0;
	endtask

	task automatic run_block(input logic zero, input logic busy);
		int target;
		lane_t d;
		target = blocks_done + 1;
		zero_block = zero;
		for (int i = 0; i < `KECCAK_LANES; i++) begin
			d = zero ? '0 : random_lane();
			push_lane(d, i == 0);
		end
		// random stalls and stray pushes until the block has left
		while (blocks_done != target) begin
			stopout = busy & 1'($random(seed));
			pushin = busy & 1'($random(seed));
			firstin = 1'($random(seed));
			din = random_lane();
			@(posedge clk);
			#1;
		end
		stopout = 1'b0;
		pushin = 1'b0;
		firstin = 1'b0;
	endtask

	// follows accepted lanes and transfers, and builds the expected result
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			in_cnt <= '0;
			out_cnt <= '0;
			held <= 1'b0;
			blocks_done <= 0;
		end else begin
			prev_dout <= dout;
			prev_firstout <= firstout;
			if (pushin && !stopin && (in_cnt != 5'd0 || firstin)) begin
				in_lanes[in_cnt] = din;
				if (in_cnt == 5'd24) begin
					for (int i = 0; i < `KECCAK_LANES; i++) begin
						model_st[i] = in_lanes[i];
					end
					model_permute();
					for (int i = 0; i < `KECCAK_LANES; i++) begin
						exp_lanes[i] <= model_st[i];
					end
					in_cnt <= '0;
					held <= 1'b1;
				end else begin
					in_cnt <= in_cnt + 5'd1;
				end
			end
			if (pushout && !stopout) begin
				if (out_cnt == 5'd24) begin
					out_cnt <= '0;
					held <= 1'b0;
					blocks_done <= blocks_done + 1;
				end else begin
					out_cnt <= out_cnt + 5'd1;
				end
			end
		end
	end

	assign exp_out = exp_lanes[out_cnt];

	a_dout_value: assert property (@(posedge clk) disable iff (rst)
		(pushout && !stopout) |-> (dout == exp_out))
		else fail_run($sformatf("Mismatch dout lane %0d: expected %h, actual %h",
			$sampled(out_cnt), $sampled(exp_out), $sampled(dout)));

	a_zero_lane0: assert property (@(posedge clk) disable iff (rst)
		(pushout && !stopout && zero_block && out_cnt == 5'd0) |->
		(dout == 64'hF1258F7940E1DDE7))
		else fail_run($sformatf("Mismatch dout: expected %h, actual %h",
			64'hF1258F7940E1DDE7, $sampled(dout)));

	a_firstout_value: assert property (@(posedge clk) disable iff (rst)
		(pushout && !stopout) |-> (firstout == (out_cnt == 5'd0)))
		else fail_run($sformatf("Mismatch firstout: expected %h, actual %h",
			$sampled(out_cnt) == 5'd0, $sampled(firstout)));

	a_firstout_alone: assert property (@(posedge clk) disable iff (rst)
		firstout |-> pushout)
		else fail_run("firstout was high without pushout");

	a_stall_push: assert property (@(posedge clk) disable iff (rst)
		(pushout && stopout) |=> pushout)
		else fail_run("pushout dropped while stopout was high");

	a_stall_dout: assert property (@(posedge clk) disable iff (rst)
		(pushout && stopout) |=> (dout == prev_dout))
		else fail_run($sformatf("Mismatch dout during stall: expected %h, actual %h",
			$sampled(prev_dout), $sampled(dout)));

	a_stall_firstout: assert property (@(posedge clk) disable iff (rst)
		(pushout && stopout) |=> (firstout == prev_firstout))
		else fail_run($sformatf("Mismatch firstout during stall: expected %h, actual %h",
			$sampled(prev_firstout), $sampled(firstout)));

	a_no_extra_output: assert property (@(posedge clk) disable iff (rst)
		pushout |-> held)
		else fail_run("an output lane appeared with no block loaded");

	a_stopin_held: assert property (@(posedge clk) disable iff (rst)
		held |-> stopin)
		else fail_run("stopin was low between the last input lane and the last output lane");

	initial begin
		seed = 36;
		clk = 1'b0;
		rst = 1'b1;
		pushin = 1'b0;
		firstin = 1'b0;
		din = '0;
		stopout = 1'b0;
		zero_block = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		// zero state, no stalls
		run_block(1'b1, 1'b0);
		// three random blocks back to back with stalls and stray pushes
		run_block(1'b0, 1'b1);
		run_block(1'b0, 1'b1);
		run_block(1'b0, 1'b1);
		// stray idle lanes, then a real block
		push_without_first(4);
		run_block(1'b0, 1'b1);
		repeat (5) @(posedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		fail_run("watchdog expired before all blocks came out");
	end

endmodule

`default_nettype wire

// File: verilog/keccak_config.svh
// lane width, grid side, lane count and round count macros
`ifndef KECCAK_CONFIG_SVH
`define KECCAK_CONFIG_SVH

// one lane of the state
`define KECCAK_LANE_W 64

// state is a 5 x 5 grid of lanes
`define KECCAK_GRID 5
`define KECCAK_LANES 25

// Keccak-f[1600] round count
`define KECCAK_ROUNDS 24

`endif

// File: verilog/keccak_perm_top.sv
// Keccak-f[1600] top level joining stream port, round engine, arbiter, RAM and rc generator
`timescale 1ns/1ps
`default_nettype none

module keccak_perm_top
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic pushin,
	input wire logic firstin,
	input wire lane_t din,
	output logic stopin,
	output logic pushout,
	output logic firstout,
	output lane_t dout,
	input wire logic stopout
);

	lane_bus_req_t port_req;
	lane_bus_req_t eng_req;
	lane_bus_req_t ram_req;
	lane_bus_rsp_t port_rsp;
	lane_bus_rsp_t eng_rsp;
	lane_bus_rsp_t ram_rsp;
	logic load_done;
	logic perm_done;
	logic restart_rc;
	logic next_rc;
	lane_t rc_lane;

	lane_stream_port i_port (
		.clk(clk),
		.rst(rst),
		.pushin(pushin),
		.firstin(firstin),
		.din(din),
		.stopout(stopout),
		.perm_done(perm_done),
		.bus_rsp(port_rsp),
		.stopin(stopin),
		.pushout(pushout),
		.firstout(firstout),
		.dout(dout),
		.load_done(load_done),
		.bus_req(port_req)
	);

	round_engine i_engine (
		.clk(clk),
		.rst(rst),
		.load_done(load_done),
		.rc_lane(rc_lane),
		.bus_rsp(eng_rsp),
		.perm_done(perm_done),
		.restart_rc(restart_rc),
		.next_rc(next_rc),
		.bus_req(eng_req)
	);

	round_constant_gen i_rc (
		.clk(clk),
		.rst(rst),
		.restart(restart_rc),
		.next_rc(next_rc),
		.rc_lane(rc_lane)
	);

	lane_bus_arbiter i_arb (
		.clk(clk),
		.rst(rst),
		.port_req(port_req),
		.eng_req(eng_req),
		.ram_rsp(ram_rsp),
		.ram_req(ram_req),
		.port_rsp(port_rsp),
		.eng_rsp(eng_rsp)
	);

	lane_ram i_ram (
		.clk(clk),
		.rst(rst),
		.req(ram_req),
		.rsp(ram_rsp)
	);

endmodule

`default_nettype wire

// File: verilog/keccak_pkg.sv
// lane, address and bus types, FSM state enums, rho and pi lookups
`default_nettype none
`include "keccak_config.svh"

package keccak_pkg;

	typedef logic [`KECCAK_LANE_W-1:0] lane_t;
	typedef logic [4:0] lane_idx_t;
	// bank bit above the lane index
	typedef logic [5:0] lane_addr_t;
	typedef logic [4:0] round_t;

	localparam logic BANK_A = 1'b0;
	localparam logic BANK_B = 1'b1;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		lane_addr_t adr;
		lane_t dat;
	} lane_bus_req_t;

	typedef struct packed {
		logic ack;
		lane_t dat;
	} lane_bus_rsp_t;

	typedef enum logic [2:0] {
		P_IDLE,
		P_LOAD,
		P_WRITE,
		P_HOLD,
		P_READ,
		P_SHOW
	} port_state_e;

	typedef enum logic [2:0] {
		E_IDLE,
		E_PAR_RD,
		E_TH_RD,
		E_TH_WR,
		E_CHI_RD,
		E_CHI_WR
	} engine_state_e;

	// rotate-left amounts, ordered by x + 5*y
	localparam logic [5:0] RHO_TAB [`KECCAK_LANES] = '{
		6'd0,  6'd1,  6'd62, 6'd28, 6'd27,
		6'd36, 6'd44, 6'd6,  6'd55, 6'd20,
		6'd3,  6'd10, 6'd43, 6'd25, 6'd39,
		6'd41, 6'd45, 6'd15, 6'd21, 6'd8,
		6'd18, 6'd2,  6'd61, 6'd56, 6'd14
	};

	function automatic logic [5:0] rho_offset(lane_idx_t idx);
		return RHO_TAB[idx];
	endfunction

	// lane (x,y) lands on (y, 2x+3y mod 5)
	function automatic lane_idx_t pi_dest(lane_idx_t idx);
		int x;
		int y;
		x = idx % `KECCAK_GRID;
		y = idx / `KECCAK_GRID;
		return lane_idx_t'(y + `KECCAK_GRID * ((2 * x + 3 * y) % `KECCAK_GRID));
	endfunction

endpackage

`default_nettype wire

// File: verilog/lane_bus_arbiter.sv
// fixed-priority two-master Wishbone classic arbiter for the lane RAM
`timescale 1ns/1ps
`default_nettype none

module lane_bus_arbiter
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire lane_bus_req_t port_req,
	input wire lane_bus_req_t eng_req,
	input wire lane_bus_rsp_t ram_rsp,
	output lane_bus_req_t ram_req,
	output lane_bus_rsp_t port_rsp,
	output lane_bus_rsp_t eng_rsp
);

	logic gnt_port;
	logic gnt_eng;
	logic own_port_q;
	logic own_eng_q;

	// engine keeps the bus while its cycle is open, otherwise the port wins
	assign gnt_port = port_req.cyc && !(own_eng_q && eng_req.cyc);
	assign gnt_eng = eng_req.cyc && !gnt_port;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			own_port_q <= 1'b0;
			own_eng_q <= 1'b0;
		end else begin
			own_port_q <= gnt_port;
			own_eng_q <= gnt_eng;
		end
	end

	always_comb begin
		if (gnt_port) begin
			ram_req = port_req;
		end else if (gnt_eng) begin
			ram_req = eng_req;
		end else begin
			ram_req = '0;
		end
	end

	// ack belongs to whoever held the bus when the RAM sampled stb
	assign port_rsp = '{ack: ram_rsp.ack && own_port_q, dat: ram_rsp.dat};
	assign eng_rsp = '{ack: ram_rsp.ack && own_eng_q, dat: ram_rsp.dat};

	// the acked master must own the request the RAM took and still hold its cycle
	a_port_ack_granted: assert property (@(posedge clk) disable iff (rst)
		port_rsp.ack |-> (port_req.cyc && $past(ram_req === port_req)))
		else $error("stream port got an ack without holding the grant");

	a_eng_ack_granted: assert property (@(posedge clk) disable iff (rst)
		eng_rsp.ack |-> (eng_req.cyc && $past(ram_req === eng_req)))
		else $error("round engine got an ack without holding the grant");

endmodule

`default_nettype wire

// File: verilog/lane_ram.sv
// two-bank lane memory with a Wishbone classic slave port
`timescale 1ns/1ps
`default_nettype none
`include "keccak_config.svh"

module lane_ram
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire lane_bus_req_t req,
	output lane_bus_rsp_t rsp
);

	localparam int DEPTH = 2 * `KECCAK_LANES;

	lane_t mem [DEPTH];
	logic ack_q;
	lane_t rdat_q;
	logic sel;
	logic [5:0] word;

	// a held request is not taken again in its ack cycle
	assign sel = req.cyc && req.stb && !ack_q;

	// bank B sits right above the 25 state lanes
	assign word = req.adr[5] ? 6'(req.adr[4:0]) + 6'(`KECCAK_LANES) : 6'(req.adr[4:0]);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= sel;
		end
	end

	always_ff @(posedge clk) begin
		if (sel) begin
			if (req.we) begin
				mem[word] <= req.dat;
			end else begin
				rdat_q <= mem[word];
			end
		end
	end

	assign rsp = '{ack: ack_q, dat: rdat_q};

	a_single_ack: assert property (@(posedge clk) disable iff (rst)
		(req.cyc && req.stb && rsp.ack) |=> !rsp.ack)
		else $error("lane RAM acknowledged one request twice");

endmodule

`default_nettype wire

// File: verilog/lane_stream_port.sv
// stream port that loads lanes into bank A and streams result lanes out
`timescale 1ns/1ps
`default_nettype none
`include "keccak_config.svh"

module lane_stream_port
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic pushin,
	input wire logic firstin,
	input wire lane_t din,
	input wire logic stopout,
	input wire logic perm_done,
	input wire lane_bus_rsp_t bus_rsp,
	output logic stopin,
	output logic pushout,
	output logic firstout,
	output lane_t dout,
	output logic load_done,
	output lane_bus_req_t bus_req
);

	port_state_e state_q;
	lane_idx_t idx_q;
	logic cyc_q;
	lane_t wdat_q;
	logic accept;
	logic last_lane;

	assign last_lane = (idx_q == lane_idx_t'(`KECCAK_LANES - 1));

	// in idle only a lane flagged by firstin opens a block
	assign accept = pushin && !stopin &&
		((state_q == P_LOAD) || (state_q == P_IDLE && firstin));

	assign bus_req = '{
		cyc: cyc_q,
		stb: cyc_q,
		we: (state_q == P_WRITE),
		adr: {BANK_A, idx_q},
		dat: wdat_q
	};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= P_IDLE;
			idx_q <= '0;
			cyc_q <= 1'b0;
			stopin <= 1'b0;
			pushout <= 1'b0;
			firstout <= 1'b0;
			load_done <= 1'b0;
		end else begin
			load_done <= 1'b0;
			case (state_q)
				P_IDLE, P_LOAD: begin
					if (accept) begin
						cyc_q <= 1'b1;
						stopin <= 1'b1;
						state_q <= P_WRITE;
					end
				end
				P_WRITE: begin
					if (bus_rsp.ack) begin
						cyc_q <= 1'b0;
						if (last_lane) begin
							// stopin stays up until the block has left
							load_done <= 1'b1;
							idx_q <= '0;
							state_q <= P_HOLD;
						end else begin
							stopin <= 1'b0;
							idx_q <= idx_q + 5'd1;
							state_q <= P_LOAD;
						end
					end
				end
				P_HOLD: begin
					if (perm_done) begin
						cyc_q <= 1'b1;
						state_q <= P_READ;
					end
				end
				P_READ: begin
					if (bus_rsp.ack) begin
						cyc_q <= 1'b0;
						pushout <= 1'b1;
						firstout <= (idx_q == '0);
						state_q <= P_SHOW;
					end
				end
				P_SHOW: begin
					if (!stopout) begin
						pushout <= 1'b0;
						firstout <= 1'b0;
						if (last_lane) begin
							idx_q <= '0;
							stopin <= 1'b0;
							state_q <= P_IDLE;
						end else begin
							idx_q <= idx_q + 5'd1;
							cyc_q <= 1'b1;
							state_q <= P_READ;
						end
					end
				end
				default: begin
					state_q <= P_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			wdat_q <= din;
		end
		if (state_q == P_READ && bus_rsp.ack) begin
			dout <= bus_rsp.dat;
		end
	end

	a_pushout_held: assert property (@(posedge clk) disable iff (rst)
		(pushout && stopout) |=> pushout)
		else $error("pushout dropped while stopout was high");

endmodule

`default_nettype wire

// File: verilog/round_constant_gen.sv
// LFSR producing the iota constant of each round
`timescale 1ns/1ps
`default_nettype none

module round_constant_gen
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic restart,
	input wire logic next_rc,
	output lane_t rc_lane
);

	logic [7:0] lfsr_q;
	logic [7:0] seed;
	logic [7:0] step_s;
	logic [7:0] lfsr_next;
	lane_t rc_next;

	// seed 01 gives a first-round constant of 1
	assign seed = restart ? 8'h01 : lfsr_q;

	// seven steps of x^8+x^6+x^5+x^4+1, bit j lands at 2^j - 1
	always_comb begin
		step_s = seed;
		rc_next = '0;
		for (int j = 0; j < 7; j++) begin
			rc_next[(1 << j) - 1] = step_s[0];
			step_s = step_s[7] ? ({step_s[6:0], 1'b0} ^ 8'h71) : {step_s[6:0], 1'b0};
		end
		lfsr_next = step_s;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr_q <= 8'h01;
			rc_lane <= '0;
		end else if (restart || next_rc) begin
			lfsr_q <= lfsr_next;
			rc_lane <= rc_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/round_engine.sv
// round engine running theta, rho, pi, chi and iota as passes over the lane RAM
`timescale 1ns/1ps
`default_nettype none
`include "keccak_config.svh"

module round_engine
	import keccak_pkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire logic load_done,
	input wire lane_t rc_lane,
	input wire lane_bus_rsp_t bus_rsp,
	output logic perm_done,
	output logic restart_rc,
	output logic next_rc,
	output lane_bus_req_t bus_req
);

	engine_state_e state_q;
	logic cyc_q;
	logic [2:0] x_q;
	logic [2:0] y_q;
	round_t round_q;
	lane_t wdat_q;
	lane_t par_q [`KECCAK_GRID];
	lane_t row_q [`KECCAK_GRID];
	lane_idx_t cur_idx;
	lane_addr_t cur_adr;
	logic [2:0] xm1;
	logic [2:0] xp1;
	logic [2:0] xp2;
	logic last_x;
	logic last_y;
	logic is_write;
	lane_t theta_lane;
	lane_t chi_lane;

	function automatic logic [2:0] col_add(logic [2:0] x, logic [2:0] k);
		logic [3:0] s;
		s = {1'b0, x} + {1'b0, k};
		return (s >= 4'd5) ? 3'(s - 4'd5) : s[2:0];
	endfunction

	function automatic lane_t rotl(lane_t v, logic [5:0] n);
		return (v << n) | (v >> (7'(`KECCAK_LANE_W) - {1'b0, n}));
	endfunction

	// index x + 5*y
	assign cur_idx = ({2'b00, y_q} << 2) + {2'b00, y_q} + {2'b00, x_q};
	assign xm1 = col_add(x_q, 3'd4);
	assign xp1 = col_add(x_q, 3'd1);
	assign xp2 = col_add(x_q, 3'd2);
	assign last_x = (x_q == 3'(`KECCAK_GRID - 1));
	assign last_y = (y_q == 3'(`KECCAK_GRID - 1));

	assign theta_lane = bus_rsp.dat ^ par_q[xm1] ^ rotl(par_q[xp1], 6'd1);
	// iota folds into the chi write of lane 0
	assign chi_lane = row_q[x_q] ^ (~row_q[xp1] & row_q[xp2]) ^
		((cur_idx == '0) ? rc_lane : '0);

	always_comb begin
		case (state_q)
			E_TH_WR: cur_adr = {BANK_B, pi_dest(cur_idx)};
			E_CHI_RD: cur_adr = {BANK_B, cur_idx};
			default: cur_adr = {BANK_A, cur_idx};
		endcase
	end

	assign is_write = (state_q == E_TH_WR) || (state_q == E_CHI_WR);

	assign bus_req = '{
		cyc: cyc_q,
		stb: cyc_q,
		we: is_write,
		adr: cur_adr,
		dat: (state_q == E_CHI_WR) ? chi_lane : wdat_q
	};

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= E_IDLE;
			cyc_q <= 1'b0;
			x_q <= '0;
			y_q <= '0;
			round_q <= '0;
			perm_done <= 1'b0;
			restart_rc <= 1'b0;
			next_rc <= 1'b0;
		end else begin
			perm_done <= 1'b0;
			restart_rc <= 1'b0;
			next_rc <= 1'b0;
			case (state_q)
				E_IDLE: begin
					if (load_done) begin
						cyc_q <= 1'b1;
						round_q <= '0;
						restart_rc <= 1'b1;
						state_q <= E_PAR_RD;
					end
				end
				E_PAR_RD, E_TH_WR: begin
					if (bus_rsp.ack) begin
						x_q <= xp1;
						if (last_x) begin
							y_q <= last_y ? 3'd0 : y_q + 3'd1;
						end
						if (last_x && last_y) begin
							state_q <= (state_q == E_PAR_RD) ? E_TH_RD : E_CHI_RD;
						end else if (state_q == E_TH_WR) begin
							state_q <= E_TH_RD;
						end
					end
				end
				E_TH_RD: begin
					if (bus_rsp.ack) begin
						state_q <= E_TH_WR;
					end
				end
				E_CHI_RD: begin
					if (bus_rsp.ack) begin
						x_q <= xp1;
						if (last_x) begin
							state_q <= E_CHI_WR;
						end
					end
				end
				E_CHI_WR: begin
					if (bus_rsp.ack) begin
						x_q <= xp1;
						if (last_x && !last_y) begin
							y_q <= y_q + 3'd1;
							state_q <= E_CHI_RD;
						end else if (last_x) begin
							y_q <= '0;
							if (round_q == round_t'(`KECCAK_ROUNDS - 1)) begin
								cyc_q <= 1'b0;
								perm_done <= 1'b1;
								state_q <= E_IDLE;
							end else begin
								round_q <= round_q + 5'd1;
								next_rc <= 1'b1;
								state_q <= E_PAR_RD;
							end
						end
					end
				end
				default: begin
					state_q <= E_IDLE;
				end
			endcase
		end
	end

	// column parities, theta result and chi row buffer
	always_ff @(posedge clk) begin
		if (bus_rsp.ack) begin
			case (state_q)
				E_PAR_RD: par_q[x_q] <= (y_q == '0) ? bus_rsp.dat : par_q[x_q] ^ bus_rsp.dat;
				E_TH_RD: wdat_q <= rotl(theta_lane, rho_offset(cur_idx));
				E_CHI_RD: row_q[x_q] <= bus_rsp.dat;
				default: ;
			endcase
		end
	end

	a_round_range: assert property (@(posedge clk) disable iff (rst)
		round_q < round_t'(`KECCAK_ROUNDS))
		else $error("round counter ran past the last round");

endmodule

`default_nettype wire
